//--- source/soc_pkg.sv
package soc_pkg;

  // master to slave half of a classic cycle
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // slave to master half
  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

  // region map, address bits 31:28
  localparam logic [3:0] REGION_RAM = 4'h0;
  localparam logic [3:0] REGION_IO  = 4'h7;
  localparam logic [3:0] REGION_ROM = 4'hf;

  // memory sizes in 32-bit words
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS);
  localparam int ROM_WORDS = 16;
  localparam int ROM_AW    = $clog2(ROM_WORDS);

  localparam int NUM_TIMERS = 4;

  // io register word offsets
  localparam int IO_AW = 3;
  localparam logic [IO_AW-1:0] IO_REG_CMP0   = 3'd0; // cmp0..cmp3 at 0..3
  localparam logic [IO_AW-1:0] IO_REG_CTRL   = 3'd4; // timer enables
  localparam logic [IO_AW-1:0] IO_REG_STATUS = 3'd5; // pending, write 1 to clear

  // exception codes seen by the cpu
  localparam logic [3:0] EXC_NONE   = 4'd0;
  localparam logic [3:0] EXC_TIMER0 = 4'd2;
  localparam logic [3:0] EXC_TIMER1 = 4'd3;
  localparam logic [3:0] EXC_TIMER2 = 4'd4;
  localparam logic [3:0] EXC_TIMER3 = 4'd5;
  localparam logic [3:0] EXC_MMU    = 4'd6;

endpackage

//--- source/wb_mmu.sv
`timescale 1ns/10ps

module wb_mmu (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t cpu_req_i,
  output soc_pkg::wb_rsp_t cpu_rsp_o,
  input  logic             supervisor_i,
  output soc_pkg::wb_req_t ram_req_o,
  input  soc_pkg::wb_rsp_t ram_rsp_i,
  output soc_pkg::wb_req_t rom_req_o,
  input  soc_pkg::wb_rsp_t rom_rsp_i,
  output soc_pkg::wb_req_t io_req_o,
  input  soc_pkg::wb_rsp_t io_rsp_i,
  output logic             fault_o
);

  logic [3:0]  region;
  logic [25:0] word_idx;
  logic        req_valid;
  logic        ram_ok;
  logic        rom_ok;
  logic        io_ok;
  logic        refuse;
  logic        err_q;

  assign region    = cpu_req_i.adr[31:28];
  assign word_idx  = cpu_req_i.adr[27:2];
  assign req_valid = cpu_req_i.cyc & cpu_req_i.stb;

  // legal targets, anything else is refused
  assign ram_ok = (region == soc_pkg::REGION_RAM) && (word_idx < soc_pkg::RAM_WORDS);
  assign rom_ok = (region == soc_pkg::REGION_ROM) && !cpu_req_i.we &&
                  (word_idx < soc_pkg::ROM_WORDS);
  assign io_ok  = (region == soc_pkg::REGION_IO) && supervisor_i;
  assign refuse = req_valid & ~(ram_ok | rom_ok | io_ok);

  always_comb
  begin
    ram_req_o     = cpu_req_i;
    rom_req_o     = cpu_req_i;
    io_req_o      = cpu_req_i;
    ram_req_o.cyc = cpu_req_i.cyc & ram_ok;
    ram_req_o.stb = cpu_req_i.stb & ram_ok;
    rom_req_o.cyc = cpu_req_i.cyc & rom_ok;
    rom_req_o.stb = cpu_req_i.stb & rom_ok;
    io_req_o.cyc  = cpu_req_i.cyc & io_ok;
    io_req_o.stb  = cpu_req_i.stb & io_ok;
  end

  // own error answer, one cycle per strobe like a slave ack
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      err_q <= 1'b0;
    else
      err_q <= refuse & ~err_q;
  end

  // request is held through ack, so the decode still selects the source
  always_comb
  begin
    cpu_rsp_o = '0;
    if (err_q)
      cpu_rsp_o.err = 1'b1;
    else if (ram_ok)
      cpu_rsp_o = ram_rsp_i;
    else if (rom_ok)
      cpu_rsp_o = rom_rsp_i;
    else if (io_ok)
      cpu_rsp_o = io_rsp_i;
  end

  assign fault_o = err_q; // one cycle fault pulse

  a_one_slave: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0({ram_req_o.stb, rom_req_o.stb, io_req_o.stb}));

  // a refused cycle never reaches a slave, so no slave may answer with it
  a_err_alone: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      err_q |-> !(ram_rsp_i.ack | rom_rsp_i.ack | io_rsp_i.ack));

endmodule

//--- source/bios_rom.sv
`timescale 1ns/10ps

module bios_rom (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t bus_req_i,
  output soc_pkg::wb_rsp_t bus_rsp_o
);

  logic [31:0]               mem [soc_pkg::ROM_WORDS];
  logic [soc_pkg::ROM_AW-1:0] idx;
  logic                      strobe;
  logic                      ack_q;
  logic [31:0]               rd_q;

  initial $readmemh("source/bios.hex", mem); // vectors sit in the top words

  assign idx    = bus_req_i.adr[soc_pkg::ROM_AW+1:2];
  assign strobe = bus_req_i.cyc & bus_req_i.stb;

  always_ff @(posedge clk_i)
  begin
    if (strobe)
      rd_q <= mem[idx];
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= strobe & ~ack_q; // single cycle ack
  end

  assign bus_rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_q};

  a_no_write: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) strobe |-> !bus_req_i.we);

endmodule

//--- source/wb_ram.sv
`timescale 1ns/10ps

module wb_ram (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t bus_req_i,
  output soc_pkg::wb_rsp_t bus_rsp_o
);

  logic [31:0]               mem [soc_pkg::RAM_WORDS];
  logic [soc_pkg::RAM_AW-1:0] idx;
  logic                      strobe;
  logic                      wr_en;
  logic                      ack_q;
  logic [31:0]               rd_q;

  assign idx    = bus_req_i.adr[soc_pkg::RAM_AW+1:2];
  assign strobe = bus_req_i.cyc & bus_req_i.stb & ~ack_q;
  assign wr_en  = strobe & bus_req_i.we;

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < 4; b++)
        if (bus_req_i.sel[b])
          mem[idx][8*b +: 8] <= bus_req_i.dat[8*b +: 8]; // byte lane b
    end
    if (strobe && !bus_req_i.we)
      rd_q <= mem[idx];
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= strobe;
  end

  assign bus_rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_q};

  a_ack_once: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) ack_q |=> !ack_q);

endmodule

//--- source/io_timers.sv
`timescale 1ns/10ps

module io_timers (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  soc_pkg::wb_req_t               bus_req_i,
  output soc_pkg::wb_rsp_t               bus_rsp_o,
  output logic [soc_pkg::NUM_TIMERS-1:0] irq_o
);

  logic [31:0]                   cmp_q [soc_pkg::NUM_TIMERS];
  logic [31:0]                   cnt_q [soc_pkg::NUM_TIMERS];
  logic [soc_pkg::NUM_TIMERS-1:0] en_q;
  logic [soc_pkg::NUM_TIMERS-1:0] pend_q;
  logic [soc_pkg::NUM_TIMERS-1:0] match;
  logic [soc_pkg::NUM_TIMERS-1:0] clr;
  logic [soc_pkg::IO_AW-1:0]      offset;
  logic                          is_cmp;
  logic                          strobe;
  logic                          wr_en;
  logic                          ack_q;
  logic [31:0]                   rd_mux;
  logic [31:0]                   rd_q;

  assign offset = bus_req_i.adr[soc_pkg::IO_AW+1:2];
  assign is_cmp = (offset[2] == soc_pkg::IO_REG_CMP0[2]); // offsets 0..3
  assign strobe = bus_req_i.cyc & bus_req_i.stb & ~ack_q;
  assign wr_en  = strobe & bus_req_i.we;
  assign clr    = (wr_en && offset == soc_pkg::IO_REG_STATUS) ?
                  bus_req_i.dat[soc_pkg::NUM_TIMERS-1:0] : '0;

  always_comb
  begin
    for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
      match[i] = en_q[i] && (cnt_q[i] == cmp_q[i]);
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
      begin
        cmp_q[i] <= '0;
        cnt_q[i] <= '0;
      end
      en_q   <= '0;
      pend_q <= '0;
      ack_q  <= 1'b0;
    end
    else
    begin
      ack_q  <= strobe;
      pend_q <= (pend_q & ~clr) | match; // match beats a clear
      for (int i = 0; i < soc_pkg::NUM_TIMERS; i++)
      begin
        if (!en_q[i] || match[i])
          cnt_q[i] <= '0;
        else
          cnt_q[i] <= cnt_q[i] + 32'd1;
      end
      if (wr_en && is_cmp)
        cmp_q[offset[1:0]] <= bus_req_i.dat;
      if (wr_en && offset == soc_pkg::IO_REG_CTRL)
        en_q <= bus_req_i.dat[soc_pkg::NUM_TIMERS-1:0];
    end
  end

  always_comb
  begin
    rd_mux = '0;
    if (is_cmp)
      rd_mux = cmp_q[offset[1:0]];
    else if (offset == soc_pkg::IO_REG_CTRL)
      rd_mux[soc_pkg::NUM_TIMERS-1:0] = en_q;
    else if (offset == soc_pkg::IO_REG_STATUS)
      rd_mux[soc_pkg::NUM_TIMERS-1:0] = pend_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (strobe)
      rd_q <= rd_mux;
  end

  assign bus_rsp_o = '{ack: ack_q, err: 1'b0, dat: rd_q};
  assign irq_o     = pend_q;

endmodule

//--- source/int_prio_enc.sv
`timescale 1ns/10ps

module int_prio_enc (
  input  logic                           fault_i,
  input  logic [soc_pkg::NUM_TIMERS-1:0] irq_i,
  input  logic                           int_en_i,
  output logic [3:0]                     exc_code_o
);

  // fault first, then timer 3 down to timer 0
  always_comb
  begin
    exc_code_o = soc_pkg::EXC_NONE;
    if (int_en_i)
    begin
      if (fault_i)
        exc_code_o = soc_pkg::EXC_MMU;
      else if (irq_i[3])
        exc_code_o = soc_pkg::EXC_TIMER3;
      else if (irq_i[2])
        exc_code_o = soc_pkg::EXC_TIMER2;
      else if (irq_i[1])
        exc_code_o = soc_pkg::EXC_TIMER1;
      else if (irq_i[0])
        exc_code_o = soc_pkg::EXC_TIMER0;
    end
  end

  always_comb
  begin
    a_src_seen: assert final (!(int_en_i && (fault_i || (|irq_i))) ||
                              (exc_code_o != soc_pkg::EXC_NONE));
  end

endmodule

//--- source/soc_core.sv
`timescale 1ns/10ps

module soc_core (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t cpu_req_i,
  output soc_pkg::wb_rsp_t cpu_rsp_o,
  input  logic             supervisor_i,
  input  logic             int_en_i,
  output logic [3:0]       exc_code_o,
  output logic             fault_o
);

  soc_pkg::wb_req_t               ram_req;
  soc_pkg::wb_rsp_t               ram_rsp;
  soc_pkg::wb_req_t               rom_req;
  soc_pkg::wb_rsp_t               rom_rsp;
  soc_pkg::wb_req_t               io_req;
  soc_pkg::wb_rsp_t               io_rsp;
  logic [soc_pkg::NUM_TIMERS-1:0] timer_irq;

  wb_mmu mmu0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cpu_req_i    (cpu_req_i),
    .cpu_rsp_o    (cpu_rsp_o),
    .supervisor_i (supervisor_i),
    .ram_req_o    (ram_req),
    .ram_rsp_i    (ram_rsp),
    .rom_req_o    (rom_req),
    .rom_rsp_i    (rom_rsp),
    .io_req_o     (io_req),
    .io_rsp_i     (io_rsp),
    .fault_o      (fault_o)
  );

  bios_rom rom0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .bus_req_i(rom_req), .bus_rsp_o(rom_rsp));

  wb_ram ram0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .bus_req_i(ram_req), .bus_rsp_o(ram_rsp));

  io_timers io0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus_req_i (io_req),
    .bus_rsp_o (io_rsp),
    .irq_o     (timer_irq)
  );

  // mmu fault joins the timer interrupts here
  int_prio_enc prio0 (
    .fault_i    (fault_o),
    .irq_i      (timer_irq),
    .int_en_i   (int_en_i),
    .exc_code_o (exc_code_o)
  );

endmodule

//--- verification/tb_soc_core.sv
`timescale 1ns/10ps

module tb_soc_core;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int RAM_TRIALS   = 8;
  // bus accesses of all tests, each takes at most 4 clocks
  localparam int ACCESSES     = RAM_TRIALS*3 + soc_pkg::ROM_WORDS + 3 + 3 + 7;
  localparam int TIMER_MARGIN = 400; // clocks spent polling the timers
  localparam logic [31:0] IO_BASE = 32'h7000_0000;

  logic             clk;
  logic             rst_n;
  soc_pkg::wb_req_t cpu_req;
  soc_pkg::wb_rsp_t cpu_rsp;
  logic             supervisor;
  logic             int_en;
  logic [3:0]       exc_code;
  logic             fault;

  // expectations of the access in flight
  logic        exp_err;
  logic        chk_rd;
  logic [31:0] exp_dat;
  logic        chk_exc;
  logic [3:0]  exp_exc;
  logic        seen_stb;

  logic [31:0] rom_img [soc_pkg::ROM_WORDS];
  logic [31:0] ram_shadow [soc_pkg::RAM_WORDS];
  string       test_name;
  int          errors;
  int          tests;
  int          test_err0;

  soc_core soc_core_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cpu_req_i    (cpu_req),
    .cpu_rsp_o    (cpu_rsp),
    .supervisor_i (supervisor),
    .int_en_i     (int_en),
    .exc_code_o   (exc_code),
    .fault_o      (fault)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic void log_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("FAILED %0s %0s expected %h actual %h", test_name, what, expected, actual);
  endfunction

  function automatic void log_problem(string msg);
    errors++;
    $display("%0s: %0s", test_name, msg);
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      seen_stb <= 1'b0;
    else if (cpu_req.stb)
      seen_stb <= 1'b1;
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_stb |-> (!cpu_rsp.ack && !cpu_rsp.err && !fault && exc_code == soc_pkg::EXC_NONE))
    else log_problem("bus response or exception active before the first strobe");

  a_answer_next: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cpu_req.stb) |=> (cpu_rsp.ack || cpu_rsp.err))
    else log_problem("no ack or err one cycle after the strobe");

  a_single_answer: assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_rsp.ack || cpu_rsp.err) |=> !(cpu_rsp.ack || cpu_rsp.err))
    else log_problem("bus answer lasted more than one cycle");

  a_resp_kind: assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_rsp.ack || cpu_rsp.err) |-> (cpu_rsp.err == exp_err && cpu_rsp.ack == !exp_err))
    else log_mismatch("err", $sampled(exp_err), $sampled(cpu_rsp.err));

  a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
    (cpu_rsp.ack && chk_rd) |-> cpu_rsp.dat == exp_dat)
    else log_mismatch("read data", $sampled(exp_dat), $sampled(cpu_rsp.dat));

  // fault only in the answer cycle of a refused access
  a_fault_is_err: assert property (@(posedge clk) disable iff (!rst_n)
    fault == (exp_err && (cpu_rsp.ack || cpu_rsp.err)))
    else log_mismatch("fault", $sampled(exp_err && (cpu_rsp.ack || cpu_rsp.err)),
                      $sampled(fault));

  a_fault_code: assert property (@(posedge clk) disable iff (!rst_n)
    (fault && int_en) |-> exc_code == soc_pkg::EXC_MMU)
    else log_mismatch("exception code", soc_pkg::EXC_MMU, $sampled(exc_code));

  a_exc_code: assert property (@(posedge clk) disable iff (!rst_n)
    chk_exc |-> exc_code == exp_exc)
    else log_mismatch("exception code", $sampled(exp_exc), $sampled(exc_code));

  // one classic cycle, held until ack or err
  task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] dat, input logic want_err, input logic check,
                           input logic [31:0] expect_dat, output logic [31:0] rd_dat);
    @(posedge clk);
    cpu_req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
    exp_err <= want_err;
    chk_rd  <= check;
    exp_dat <= expect_dat;
    do
      @(posedge clk);
    while (!(cpu_rsp.ack || cpu_rsp.err));
    rd_dat = cpu_rsp.dat;
    cpu_req <= '0;
    chk_rd  <= 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat, input logic want_err);
    logic [31:0] unused;
    bus_cycle(1'b1, sel, adr, dat, want_err, 1'b0, '0, unused);
  endtask

  task automatic bus_read(input logic [31:0] adr, input logic check, input logic [31:0] expect_dat,
                          input logic want_err, output logic [31:0] rd_dat);
    bus_cycle(1'b0, 4'hf, adr, '0, want_err, check, expect_dat, rd_dat);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("test %0s done, %0d errors", test_name, errors - test_err0);
  endtask

  initial
  begin
    #(CLK_PERIOD * (RESET_CYCLES + ACCESSES*4 + TIMER_MARGIN));
    $display("watchdog: the run hung, tests did not finish in time");
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    logic [9:0]  idx;
    logic [3:0]  sel;
    logic [31:0] full;
    logic [31:0] part;
    logic [31:0] adr;
    logic [31:0] rd;

    errors = 0;
    tests  = 0;
    test_name = "reset";
    void'($urandom(32'h4ddd));
    $readmemh("source/bios.hex", rom_img);
    rst_n      <= 1'b0;
    cpu_req    <= '0;
    supervisor <= 1'b0;
    int_en     <= 1'b0;
    exp_err    <= 1'b0;
    chk_rd     <= 1'b0;
    exp_dat    <= '0;
    chk_exc    <= 1'b0;
    exp_exc    <= soc_pkg::EXC_NONE;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset");
    int_en <= 1'b1; // encoder live, so a stray source would show
    repeat (4) @(posedge clk); // quiet bus checked by assertion
    end_test();

    start_test("ram");
    for (int t = 0; t < RAM_TRIALS; t++)
    begin
      idx  = $urandom_range(soc_pkg::RAM_WORDS-1);
      sel  = $urandom;
      full = $urandom;
      part = $urandom;
      adr  = {20'h0, idx, 2'b00};
      bus_write(adr, 4'hf, full, 1'b0);
      ram_shadow[idx] = full;
      bus_write(adr, sel, part, 1'b0);
      for (int b = 0; b < 4; b++)
        if (sel[b])
          ram_shadow[idx][8*b +: 8] = part[8*b +: 8];
      bus_read(adr, 1'b1, ram_shadow[idx], 1'b0, rd);
    end
    end_test();

    start_test("rom");
    for (int w = 0; w < soc_pkg::ROM_WORDS; w++)
      bus_read(32'hf000_0000 + 4*w, 1'b1, rom_img[w], 1'b0, rd);
    bus_write(32'hf000_0004, 4'hf, 32'h1234_5678, 1'b1); // rom is read only
    bus_read(32'h3000_0000, 1'b0, '0, 1'b1, rd);         // unmapped region
    bus_read(32'h0000_1000, 1'b0, '0, 1'b1, rd);         // word 1024, past ram
    end_test();

    start_test("io_protect");
    int_en <= 1'b1;
    bus_write(IO_BASE + 4, 4'hf, 32'h0000_00a5, 1'b1); // user mode
    supervisor <= 1'b1;
    bus_write(IO_BASE + 4, 4'hf, 32'h0000_00a5, 1'b0);
    bus_read(IO_BASE + 4, 1'b1, 32'h0000_00a5, 1'b0, rd);
    int_en <= 1'b0;
    end_test();

    start_test("timers");
    bus_write(IO_BASE + 4*0, 4'hf, 32'd5, 1'b0);
    bus_write(IO_BASE + 4*2, 4'hf, 32'd9, 1'b0);
    bus_write(IO_BASE + 4*soc_pkg::IO_REG_CTRL, 4'hf, 32'h5, 1'b0);
    rd = '0;
    while ((rd & 32'h5) != 32'h5)
      bus_read(IO_BASE + 4*soc_pkg::IO_REG_STATUS, 1'b0, '0, 1'b0, rd);
    int_en  <= 1'b1;
    exp_exc <= soc_pkg::EXC_TIMER2;
    chk_exc <= 1'b1;
    repeat (4) @(posedge clk);
    int_en  <= 1'b0;
    exp_exc <= soc_pkg::EXC_NONE;
    repeat (4) @(posedge clk);
    int_en  <= 1'b1;
    exp_exc <= soc_pkg::EXC_TIMER2;
    bus_write(IO_BASE + 4*soc_pkg::IO_REG_CTRL, 4'hf, 32'h1, 1'b0); // stop timer 2 first
    chk_exc <= 1'b0; // code moves while the clear lands
    bus_write(IO_BASE + 4*soc_pkg::IO_REG_STATUS, 4'hf, 32'h4, 1'b0);
    exp_exc <= soc_pkg::EXC_TIMER0;
    chk_exc <= 1'b1;
    repeat (4) @(posedge clk);
    bus_write(IO_BASE + 4*soc_pkg::IO_REG_CTRL, 4'hf, 32'h0, 1'b0);
    chk_exc <= 1'b0;
    bus_write(IO_BASE + 4*soc_pkg::IO_REG_STATUS, 4'hf, 32'h5, 1'b0);
    exp_exc <= soc_pkg::EXC_NONE;
    chk_exc <= 1'b1;
    repeat (4) @(posedge clk);
    chk_exc <= 1'b0;
    int_en  <= 1'b0;
    @(posedge clk);
    end_test();

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- source/bios.hex
// one 32-bit rom word per line in hex, word 0 first, vectors in the top words
3c1d7000
27bd0ff0
3c080000
25080400
ad000000
25080004
1500fffd
00000000
0bc00010
00000000
f0000040
f0000080
f00000c0
f0000100
f0000140
f0000020

//--- filelist.f
source/soc_pkg.sv
source/wb_mmu.sv
source/bios_rom.sv
source/wb_ram.sv
source/io_timers.sv
source/int_prio_enc.sv
source/soc_core.sv
verification/tb_soc_core.sv
